// File: udp_pkg.sv
`default_nettype none

package udp_pkg;

    // lane and port counts
    localparam int NUM_LANES   = 2;
    localparam int NUM_PORTS   = 5;
    // queue entries, and the credits each queue starts with
    localparam int QUEUE_DEPTH = 4;

    typedef logic [15:0] udp_port_t;
    typedef logic [63:0] hdr_word_t;
    typedef logic [2:0]  port_idx_t;
    typedef logic [2:0]  credit_t;
    typedef logic [2:0]  loopback_t;
    typedef logic [31:0] csr_word_t;
    typedef logic [3:0]  csr_addr_t;
    typedef logic [15:0] drop_cnt_t;

    // inbound port table, index 0 first
    localparam udp_port_t PORT_VALUE [NUM_PORTS] = '{
        16'd21618,
        16'd21614,
        16'd21603,
        16'd21601,
        16'd21608
    };

    // set bits are don't care, entry 0 covers 21616 to 21623
    localparam udp_port_t PORT_MASK [NUM_PORTS] = '{
        16'h0007,
        16'h0000,
        16'h0000,
        16'h0000,
        16'h0000
    };

    // per-lane status word layout
    localparam int STAT_PHY_RST    = 0;
    localparam int STAT_PLL_LOCK   = 1;
    localparam int STAT_BLOCK_LOCK = 2;
    localparam int STAT_HIGH_BER   = 3;
    localparam int STAT_EYE_RST    = 4;
    localparam int STAT_LOOPBACK   = 8;

    // register map
    localparam int        ADDR_LANE_BIT = 2;
    localparam csr_addr_t ADDR_DROP     = 4'd8;

endpackage

`default_nettype wire

// File: dispatch_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dispatch_if;
    import udp_pkg::*;

    // one-hot push, registered in the dispatcher
    logic [NUM_PORTS-1:0] push;
    hdr_word_t            push_data;
    port_idx_t            push_idx;
    // one pulse per pop, from each queue
    logic [NUM_PORTS-1:0] credit_ret;

    modport dispatcher (
        output push,
        output push_data,
        output push_idx,
        input  credit_ret
    );

    modport queue (
        input  push,
        input  push_data,
        input  push_idx,
        output credit_ret
    );

endinterface

`default_nettype wire

// File: lane_csr.sv
`timescale 1ns/1ps
`default_nettype none

module lane_csr (
    input  wire logic                                  wb_clk_i,
    input  wire logic                                  rst_n_i,
    input  wire logic                                  wb_cyc_i,
    input  wire logic                                  wb_stb_i,
    input  wire logic                                  wb_we_i,
    input  wire udp_pkg::csr_addr_t                    wb_adr_i,
    input  wire logic [3:0]                            wb_sel_i,
    input  wire udp_pkg::csr_word_t                    wb_dat_i,
    output udp_pkg::csr_word_t                         wb_dat_o,
    output logic                                       wb_ack_o,
    input  wire logic                                  pll_lock_i,
    input  wire logic [udp_pkg::NUM_LANES-1:0]         block_lock_i,
    input  wire logic [udp_pkg::NUM_LANES-1:0]         high_ber_i,
    input  wire udp_pkg::drop_cnt_t                    drop_cnt_i,
    output logic                                       phy_rst_o,
    output logic [udp_pkg::NUM_LANES-1:0]              eye_rst_o,
    output udp_pkg::loopback_t [udp_pkg::NUM_LANES-1:0] loopback_o
);
    import udp_pkg::*;

    logic      req;
    logic      wr_req;
    logic      rd_req;
    logic      drop_sel;
    logic      lane;
    logic      ack_q;
    csr_word_t stat_word [NUM_LANES];

    assign req      = wb_cyc_i && wb_stb_i;
    assign wr_req   = req && wb_we_i;
    assign rd_req   = req && !wb_we_i;
    assign drop_sel = (wb_adr_i == ADDR_DROP);
    // address bit 2 picks the lane
    assign lane     = wb_adr_i[ADDR_LANE_BIT];

    // status word for each lane
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            stat_word[l] = '0;
            stat_word[l][STAT_PHY_RST]    = phy_rst_o;
            stat_word[l][STAT_PLL_LOCK]   = pll_lock_i;
            stat_word[l][STAT_BLOCK_LOCK] = block_lock_i[l];
            stat_word[l][STAT_HIGH_BER]   = high_ber_i[l];
            stat_word[l][STAT_EYE_RST]    = eye_rst_o[l];
            stat_word[l][STAT_LOOPBACK +: $bits(loopback_t)] = loopback_o[l];
        end
    end

    // control registers, byte lanes 0 and 1 only
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            phy_rst_o  <= 1'b0;
            eye_rst_o  <= '0;
            loopback_o <= '0;
        end else if (wr_req && !drop_sel) begin
            if (wb_sel_i[0]) begin
                // phy reset is shared by both lanes
                phy_rst_o       <= wb_dat_i[STAT_PHY_RST];
                eye_rst_o[lane] <= wb_dat_i[STAT_EYE_RST];
            end
            if (wb_sel_i[1]) begin
                loopback_o[lane] <= wb_dat_i[STAT_LOOPBACK +: $bits(loopback_t)];
            end
        end
    end

    // read data taken in the request cycle
    always_ff @(posedge wb_clk_i) begin
        if (rd_req) begin
            wb_dat_o <= drop_sel ? csr_word_t'(drop_cnt_i) : stat_word[lane];
        end
    end

    // single-cycle ack, even if stb is held through it
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req && !ack_q;
        end
    end

    assign wb_ack_o = ack_q && wb_cyc_i;

endmodule

`default_nettype wire

// File: udp_port_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module udp_port_dispatch (
    input  wire logic               wb_clk_i,
    input  wire logic               rst_n_i,
    input  wire logic               hdr_valid_i,
    output logic                    hdr_ready_o,
    input  wire udp_pkg::hdr_word_t hdr_data_i,
    input  wire udp_pkg::udp_port_t hdr_dport_i,
    dispatch_if.dispatcher          disp,
    output udp_pkg::drop_cnt_t      drop_cnt_o
);
    import udp_pkg::*;

    logic [NUM_PORTS-1:0] hit;
    logic                 matched;
    port_idx_t            match_idx;
    logic                 take;
    credit_t              credit [NUM_PORTS];
    logic [NUM_PORTS-1:0] push_q;
    port_idx_t            push_idx_q;
    hdr_word_t            push_data_q;

    // masked compare against every table entry
    always_comb begin
        for (int k = 0; k < NUM_PORTS; k++) begin
            hit[k] = ((hdr_dport_i ^ PORT_VALUE[k]) & ~PORT_MASK[k]) == '0;
        end
    end

    // lowest index wins
    always_comb begin
        matched   = 1'b0;
        match_idx = '0;
        for (int k = NUM_PORTS - 1; k >= 0; k--) begin
            if (hit[k]) begin
                matched   = 1'b1;
                match_idx = port_idx_t'(k);
            end
        end
    end

    // unmatched headers are always accepted and dropped
    assign hdr_ready_o = !matched || (credit[match_idx] != '0);
    assign take        = hdr_valid_i && hdr_ready_o;

    // credit is spent when the header is accepted, one cycle before the push
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < NUM_PORTS; k++) begin
                credit[k] <= credit_t'(QUEUE_DEPTH);
            end
        end else begin
            for (int k = 0; k < NUM_PORTS; k++) begin
                case ({take && matched && (match_idx == port_idx_t'(k)), disp.credit_ret[k]})
                    2'b10:   credit[k] <= credit[k] - 3'd1;
                    2'b01:   credit[k] <= credit[k] + 3'd1;
                    default: credit[k] <= credit[k];
                endcase
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            push_q <= '0;
        end else begin
            push_q <= '0;
            if (take && matched) begin
                push_q[match_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (take) begin
            push_data_q <= hdr_data_i;
            push_idx_q  <= match_idx;
        end
    end

    // saturating drop counter
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            drop_cnt_o <= '0;
        end else if (take && !matched && (drop_cnt_o != '1)) begin
            drop_cnt_o <= drop_cnt_o + 16'd1;
        end
    end

    assign disp.push      = push_q;
    assign disp.push_data = push_data_q;
    assign disp.push_idx  = push_idx_q;

endmodule

`default_nettype wire

// File: port_queue.sv
`timescale 1ns/1ps
`default_nettype none

module port_queue #(
    parameter udp_pkg::port_idx_t PORT_IDX = 3'd0
) (
    input  wire logic          wb_clk_i,
    input  wire logic          rst_n_i,
    dispatch_if.queue          disp,
    output logic               out_valid_o,
    output udp_pkg::hdr_word_t out_data_o,
    input  wire logic          out_ready_i
);
    import udp_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    hdr_word_t        mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    credit_t          fill;
    logic             wr_en;
    logic             rd_en;
    logic             pop;
    logic             credit_q;

    // one-hot push qualified by the index
    assign wr_en = disp.push[PORT_IDX] && (disp.push_idx == PORT_IDX);
    assign pop   = out_valid_o && out_ready_i;
    // refill the output register when it is empty or being popped
    assign rd_en = (fill != '0) && (!out_valid_o || pop);

    always_ff @(posedge wb_clk_i) begin
        if (wr_en) begin
            mem[wr_ptr] <= disp.push_data;
        end
        if (rd_en) begin
            out_data_o <= mem[rd_ptr];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            fill        <= '0;
            out_valid_o <= 1'b0;
            credit_q    <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   fill <= fill + 3'd1;
                2'b01:   fill <= fill - 3'd1;
                default: fill <= fill;
            endcase
            if (rd_en) begin
                out_valid_o <= 1'b1;
            end else if (pop) begin
                out_valid_o <= 1'b0;
            end
            // one credit back per pop
            credit_q <= pop;
        end
    end

    assign disp.credit_ret[PORT_IDX] = credit_q;

endmodule

`default_nettype wire

// File: udp_lane_top.sv
`timescale 1ns/1ps
`default_nettype none

module udp_lane_top (
    input  wire logic                                     wb_clk_i,
    input  wire logic                                     rst_n_i,
    // wishbone
    input  wire logic                                     wb_cyc_i,
    input  wire logic                                     wb_stb_i,
    input  wire logic                                     wb_we_i,
    input  wire udp_pkg::csr_addr_t                       wb_adr_i,
    input  wire logic [3:0]                               wb_sel_i,
    input  wire udp_pkg::csr_word_t                       wb_dat_i,
    output udp_pkg::csr_word_t                            wb_dat_o,
    output logic                                          wb_ack_o,
    // lane status and control
    input  wire logic                                     pll_lock_i,
    input  wire logic [udp_pkg::NUM_LANES-1:0]            block_lock_i,
    input  wire logic [udp_pkg::NUM_LANES-1:0]            high_ber_i,
    output logic                                          phy_rst_o,
    output logic [udp_pkg::NUM_LANES-1:0]                 eye_rst_o,
    output logic [udp_pkg::NUM_LANES*3-1:0]               loopback_o,
    // inbound headers
    input  wire logic                                     hdr_valid_i,
    output logic                                          hdr_ready_o,
    input  wire udp_pkg::hdr_word_t                       hdr_data_i,
    input  wire udp_pkg::udp_port_t                       hdr_dport_i,
    // per-port outputs, port 0 lowest
    output logic [udp_pkg::NUM_PORTS-1:0]                 out_valid_o,
    output logic [udp_pkg::NUM_PORTS*64-1:0]              out_data_o,
    input  wire logic [udp_pkg::NUM_PORTS-1:0]            out_ready_i
);
    import udp_pkg::*;

    drop_cnt_t drop_cnt;

    dispatch_if disp_bus ();

    lane_csr u_csr (
        .wb_clk_i     (wb_clk_i),
        .rst_n_i      (rst_n_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_sel_i     (wb_sel_i),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .pll_lock_i   (pll_lock_i),
        .block_lock_i (block_lock_i),
        .high_ber_i   (high_ber_i),
        .drop_cnt_i   (drop_cnt),
        .phy_rst_o    (phy_rst_o),
        .eye_rst_o    (eye_rst_o),
        .loopback_o   (loopback_o)
    );

    udp_port_dispatch u_dispatch (
        .wb_clk_i    (wb_clk_i),
        .rst_n_i     (rst_n_i),
        .hdr_valid_i (hdr_valid_i),
        .hdr_ready_o (hdr_ready_o),
        .hdr_data_i  (hdr_data_i),
        .hdr_dport_i (hdr_dport_i),
        .disp        (disp_bus.dispatcher),
        .drop_cnt_o  (drop_cnt)
    );

    // one queue per inbound port
    for (genvar k = 0; k < NUM_PORTS; k++) begin : g_queue
        port_queue #(
            .PORT_IDX (port_idx_t'(k))
        ) u_queue (
            .wb_clk_i    (wb_clk_i),
            .rst_n_i     (rst_n_i),
            .disp        (disp_bus.queue),
            .out_valid_o (out_valid_o[k]),
            .out_data_o  (out_data_o[k*$bits(hdr_word_t) +: $bits(hdr_word_t)]),
            .out_ready_i (out_ready_i[k])
        );
    end

endmodule

`default_nettype wire

// File: tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
    input  wire logic                             wb_clk_i,
    input  wire logic                             rst_n_i,
    input  wire logic                             we_i,
    input  wire logic                             ack_i,
    input  wire udp_pkg::csr_word_t               rd_data_i,
    input  wire logic                             hdr_ready_i,
    input  wire logic [8:0]                       ctrl_i,
    input  wire logic [udp_pkg::NUM_PORTS-1:0]    out_valid_i,
    input  wire logic [udp_pkg::NUM_PORTS*64-1:0] out_data_i,
    input  wire logic [udp_pkg::NUM_PORTS-1:0]    out_ready_i,
    output int                                    output_err_o,
    output int                                    call_err_o
);
    import udp_pkg::*;

    // one scoreboard per port plus one for reads in request order
    hdr_word_t hdr_exp [NUM_PORTS][$];
    string     hdr_name [NUM_PORTS][$];
    csr_word_t rd_exp [$];
    string     rd_name [$];
    int        seen_err = 0;
    int        call_err = 0;

    assign output_err_o = seen_err;
    assign call_err_o   = call_err;

    function automatic bit report_mismatch(input string name, input logic [63:0] exp,
                                           input logic [63:0] act);
        if (exp !== act) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic expect_hdr(input int port, input hdr_word_t data, input string name);
        hdr_exp[port].push_back(data);
        hdr_name[port].push_back(name);
    endtask

    task automatic expect_read(input csr_word_t data, input string name);
        rd_exp.push_back(data);
        rd_name.push_back(name);
    endtask

    // ctrl_i is {phy reset, eye reset[1:0], loopback[5:0]}
    task automatic check_ctrl(input string name, input logic [8:0] exp);
        if (report_mismatch(name, 64'(exp), 64'(ctrl_i))) call_err++;
    endtask

    task automatic check_stalled(input string name);
        if (hdr_ready_i) begin
            $display("%s: header input was ready although the queue had no credit", name);
            call_err++;
        end
    endtask

    function automatic int pending_count();
        int n;
        n = rd_exp.size();
        for (int k = 0; k < NUM_PORTS; k++) n += hdr_exp[k].size();
        return n;
    endfunction

    always @(posedge wb_clk_i) begin
        if (rst_n_i) begin
            for (int k = 0; k < NUM_PORTS; k++) begin
                if (out_valid_i[k] && out_ready_i[k]) begin
                    if (hdr_exp[k].size() == 0) begin
                        $display("port %0d delivered a header that was never sent to it", k);
                        seen_err++;
                    end else if (report_mismatch(hdr_name[k].pop_front(), hdr_exp[k].pop_front(),
                                                 out_data_i[k*64 +: 64])) begin
                        seen_err++;
                    end
                end
            end
            if (ack_i && !we_i) begin
                if (rd_exp.size() == 0) begin
                    $display("read acknowledged with no read outstanding");
                    seen_err++;
                end else if (report_mismatch(rd_name.pop_front(), 64'(rd_exp.pop_front()),
                                             64'(rd_data_i))) begin
                    seen_err++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_udp_lane.sv
`timescale 1ns/1ps
`default_nettype none

module tb_udp_lane;
    import udp_pkg::*;

    typedef enum int {OP_WR, OP_RD, OP_HDR, OP_STALL, OP_RDY, OP_STAT} op_t;

    // arg is address, port, ready mask or status bits; exp is the port the header leaves on
    typedef struct packed {
        op_t         kind;
        int          arg;
        int          sel;
        logic [31:0] data;
        int          exp;
    } row_t;

    row_t         rows [$];
    string        names [$];
    logic         wb_clk_i;
    logic         rst_n_i;
    logic         wb_cyc_i;
    logic         wb_stb_i;
    logic         wb_we_i;
    logic         wb_ack_o;
    csr_addr_t    wb_adr_i;
    logic [3:0]   wb_sel_i;
    csr_word_t    wb_dat_i;
    csr_word_t    wb_dat_o;
    logic         pll_lock_i;
    logic         phy_rst_o;
    logic         hdr_valid_i;
    logic         hdr_ready_o;
    logic [1:0]   block_lock_i;
    logic [1:0]   high_ber_i;
    logic [1:0]   eye_rst_o;
    logic [5:0]   loopback_o;
    hdr_word_t    hdr_data_i;
    udp_port_t    hdr_dport_i;
    logic [4:0]   out_valid_o;
    logic [4:0]   out_ready_i;
    logic [319:0] out_data_o;
    int           output_err;
    int           call_err;
    // register and drop model
    logic         m_phy;
    logic         m_pll;
    logic [1:0]   m_eye;
    logic [1:0]   m_block;
    logic [1:0]   m_ber;
    logic [5:0]   m_lb;
    int           m_drops;
    bit           hdr_pending;

    udp_lane_top dut_i (.*);

    tb_checker chk_i (
        .wb_clk_i     (wb_clk_i),
        .rst_n_i      (rst_n_i),
        .we_i         (wb_we_i),
        .ack_i        (wb_ack_o),
        .rd_data_i    (wb_dat_o),
        .hdr_ready_i  (hdr_ready_o),
        .ctrl_i       ({phy_rst_o, eye_rst_o, loopback_o}),
        .out_valid_i  (out_valid_o),
        .out_data_i   (out_data_o),
        .out_ready_i  (out_ready_i),
        .output_err_o (output_err),
        .call_err_o   (call_err)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #4 wb_clk_i = ~wb_clk_i;
    end

    // entry 0 ignores the low three bits
    function automatic int route_port(input int p);
        if (p >= 21616 && p <= 21623) return 0;
        case (p)
            21614:   return 1;
            21603:   return 2;
            21601:   return 3;
            21608:   return 4;
            default: return NUM_PORTS;
        endcase
    endfunction

    function automatic csr_word_t lane_status(input int lane);
        csr_word_t w;
        w = '0;
        w[0] = m_phy;
        w[1] = m_pll;
        w[2] = m_block[lane];
        w[3] = m_ber[lane];
        w[4] = m_eye[lane];
        w[10:8] = m_lb[lane*3 +: 3];
        return w;
    endfunction

    task automatic add_row(input op_t kind, input int arg, input int sel, input logic [31:0] data,
                           input int exp, input string name);
        rows.push_back('{kind, arg, sel, data, exp});
        names.push_back(name);
    endtask

    task automatic add_header(input int dport, input string name);
        add_row(OP_HDR, dport, 0, 0, route_port(dport), name);
    endtask

    task automatic wb_cycle(input logic we, input int addr, input int sel,
                            input logic [31:0] data);
        @(negedge wb_clk_i);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = csr_addr_t'(addr);
        wb_sel_i = 4'(sel);
        wb_dat_i = data;
        @(posedge wb_clk_i);
        while (!wb_ack_o) @(posedge wb_clk_i);
        @(negedge wb_clk_i);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
    endtask

    task automatic wb_write(input int addr, input int sel, input logic [31:0] data,
                            input string name);
        int lane;
        lane = (addr >> 2) & 1;
        wb_cycle(1'b1, addr, sel, data);
        if (addr != 8 && sel[0]) begin
            m_phy = data[0];
            m_eye[lane] = data[4];
        end
        if (addr != 8 && sel[1]) m_lb[lane*3 +: 3] = data[10:8];
        chk_i.check_ctrl(name, {m_phy, m_eye, m_lb});
    endtask

    task automatic wb_read(input int addr, input string name);
        csr_word_t exp;
        exp = (addr == 8) ? csr_word_t'(m_drops) : lane_status((addr >> 2) & 1);
        chk_i.expect_read(exp, name);
        wb_cycle(1'b0, addr, 0, 32'h0);
    endtask

    task automatic wait_take();
        @(posedge wb_clk_i);
        while (!hdr_ready_o) @(posedge wb_clk_i);
        @(negedge wb_clk_i);
        hdr_valid_i = 1'b0;
        hdr_pending = 1'b0;
    endtask

    task automatic send_header(input int dport, input int port, input int stall,
                               input string name);
        hdr_word_t data;
        data = {$urandom, $urandom};
        if (port < NUM_PORTS) chk_i.expect_hdr(port, data, name);
        else m_drops++;
        @(negedge wb_clk_i);
        hdr_valid_i = 1'b1;
        hdr_dport_i = udp_port_t'(dport);
        hdr_data_i  = data;
        if (stall == 0) begin
            wait_take();
        end else begin
            // the header stays offered until a ready row frees a credit
            repeat (stall) begin
                @(posedge wb_clk_i);
                chk_i.check_stalled(name);
            end
            hdr_pending = 1'b1;
        end
    endtask

    task automatic set_ready(input int mask);
        @(negedge wb_clk_i);
        out_ready_i = 5'(mask);
        if (hdr_pending) wait_take();
    endtask

    task automatic set_status(input int bits);
        @(negedge wb_clk_i);
        {high_ber_i, block_lock_i, pll_lock_i} = 5'(bits);
        {m_ber, m_block, m_pll} = 5'(bits);
    endtask

    task automatic build_table();
        add_row(OP_RD, 8, 0, 0, 0, "reset_drop");
        add_row(OP_RD, 4, 0, 0, 0, "reset_lane1");
        add_row(OP_WR, 0, 3, 32'h511, 0, "wr_lane0_all");
        add_row(OP_RD, 0, 0, 0, 0, "rd_lane0_ctrl");
        add_row(OP_WR, 4, 1, 32'h710, 0, "wr_lane1_no_lb");
        add_row(OP_RD, 4, 0, 0, 0, "rd_lane1_ctrl");
        add_row(OP_WR, 4, 2, 32'h311, 0, "wr_lane1_lb_only");
        add_row(OP_RD, 4, 0, 0, 0, "rd_lane1_lb");
        add_row(OP_WR, 8, 15, 32'hffff_ffff, 0, "wr_drop_ignored");
        add_row(OP_RD, 8, 0, 0, 0, "rd_drop_still_zero");
        add_row(OP_RD, 0, 0, 0, 0, "rd_lane0_after");
        // pll 1, block lock lane 0, high ber lane 1, then the reverse
        add_row(OP_STAT, 19, 0, 0, 0, "status_a");
        add_row(OP_RD, 0, 0, 0, 0, "stat_a_lane0");
        add_row(OP_RD, 4, 0, 0, 0, "stat_a_lane1");
        add_row(OP_STAT, 12, 0, 0, 0, "status_b");
        add_row(OP_RD, 0, 0, 0, 0, "stat_b_lane0");
        add_row(OP_RD, 4, 0, 0, 0, "stat_b_lane1");
        add_row(OP_RDY, 31, 0, 0, 0, "all_ready");
        add_header(21618, "hdr_p0_exact");
        add_header(21614, "hdr_p1");
        add_header(21603, "hdr_p2");
        add_header(21601, "hdr_p3");
        add_header(21608, "hdr_p4");
        add_header(21616, "hdr_p0_low");
        add_header(21620, "hdr_p0_mid");
        add_header(21623, "hdr_p0_high");
        add_header(21614, "hdr_p1_second");
        add_header(21614, "hdr_p1_third");
        add_header(21552, "hdr_drop_a");
        add_header(21624, "hdr_drop_b");
        add_header(21600, "hdr_drop_c");
        add_row(OP_RD, 8, 0, 0, 0, "rd_drop_three");
        // ports 1 and 2 held so the fifth header to port 2 must wait
        add_row(OP_RDY, 25, 0, 0, 0, "hold_p1_p2");
        add_header(21614, "stall_p1_a");
        add_header(21614, "stall_p1_b");
        for (int i = 1; i <= 4; i++) begin
            add_header(21603, $sformatf("stall_p2_%0d", i));
        end
        add_row(OP_STALL, 21603, 0, 6, route_port(21603), "stall_p2_5");
        add_row(OP_RDY, 31, 0, 0, 0, "release_all");
        add_row(OP_RD, 8, 0, 0, 0, "rd_drop_final");
    endtask

    initial begin
        void'($urandom(28247));
        {rst_n_i, wb_cyc_i, wb_stb_i, wb_we_i, wb_adr_i, wb_sel_i, wb_dat_i} = '0;
        {pll_lock_i, block_lock_i, high_ber_i, out_ready_i} = '0;
        {hdr_valid_i, hdr_data_i, hdr_dport_i} = '0;
        {m_phy, m_pll, m_eye, m_block, m_ber, m_lb} = '0;
        m_drops = 0;
        hdr_pending = 1'b0;
        build_table();
        repeat (10) @(posedge wb_clk_i);
        @(negedge wb_clk_i);
        rst_n_i = 1'b1;
        chk_i.check_ctrl("reset_ctrl", 9'h0);
        for (int i = 0; i < rows.size(); i++) begin
            case (rows[i].kind)
                OP_WR:    wb_write(rows[i].arg, rows[i].sel, rows[i].data, names[i]);
                OP_RD:    wb_read(rows[i].arg, names[i]);
                OP_HDR:   send_header(rows[i].arg, rows[i].exp, 0, names[i]);
                OP_STALL: send_header(rows[i].arg, rows[i].exp, int'(rows[i].data), names[i]);
                OP_RDY:   set_ready(rows[i].arg);
                default:  set_status(rows[i].arg);
            endcase
        end
        while (chk_i.pending_count() != 0) @(posedge wb_clk_i);
        repeat (10) @(posedge wb_clk_i);
        $display("checks done: %0d output errors, %0d control errors", output_err, call_err);
        if (output_err + call_err == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // watchdog allows 20 cycles per row
    initial begin
        @(posedge rst_n_i);
        repeat (rows.size() * 20) @(posedge wb_clk_i);
        $display("timeout: the run did not finish within %0d cycles", rows.size() * 20);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
udp_pkg.sv
dispatch_if.sv
lane_csr.sv
udp_port_dispatch.sv
port_queue.sv
udp_lane_top.sv
tb_checker.sv
tb_udp_lane.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_udp_lane
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)
